// ==== alu_cluster.f ====
common/alu_pkg.sv
alu/alu_32.sv
alu/alu_lane.sv
src/op_dispatch.sv
src/result_collect.sv
src/alu_cluster.sv
verification/alu_cluster_tb.sv

// ==== Makefile ====
# ALU cluster simulation with Verilator
SOURCES := $(shell cat alu_cluster.f)

.PHONY: run clean

run: obj_dir/Valu_cluster_tb
	@out="$$(./obj_dir/Valu_cluster_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

# rebuilt only when a source or the file list changes
obj_dir/Valu_cluster_tb: alu_cluster.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/100ps \
	  --top-module alu_cluster_tb -f alu_cluster.f

clean:
	rm -rf obj_dir

// ==== verification/alu_cluster_tb.sv ====
/* testbench for the ALU cluster
   random and directed requests checked in order against a reference model */
`default_nettype none
`timescale 1ns/100ps

module alu_cluster_tb;
  import alu_pkg::*;

  localparam int          wait_limit = 200;
  localparam logic [31:0] lfsr_taps  = 32'ha3000000;
  localparam longint      word_max   = 64'sh7fffffff;
  localparam longint      word_min   = -64'sh80000000;

  logic     clk;
  logic     reset;
  logic     in_valid;
  logic     in_ready;
  alu_req_t in_req;
  logic     out_valid;
  logic     out_ready;
  alu_rsp_t out_rsp;

  logic [31:0] lfsr_state = 32'ha5f80a6e;
  tag_t        next_tag = '0;
  alu_rsp_t    expect_q [$];  // predicted responses in acceptance order
  int          check_count = 0;
  int          err_count = 0;
  int          checks_mark = 0;
  int          errs_mark = 0;
  int          accepted_n = 0;
  int          returned_n = 0;

  alu_cluster uut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ lfsr_taps : lfsr_state >> 1;
    end
    return v;
  endfunction

  function automatic word_t rand_word();
    return word_t'(rand_bits(32));
  endfunction

  function automatic op_t logic_op();
    logic [1:0] sel;
    sel = 2'(rand_bits(2));
    case (sel)
      2'd0:    return op_and;
      2'd1:    return op_or;
      2'd2:    return op_nor;
      default: return op_slt;
    endcase
  endfunction

  function automatic op_t arith_op();
    logic [1:0] sel;
    sel = 2'(rand_bits(2));
    case (sel)
      2'd1:    return op_addu;
      2'd2:    return op_sub;
      default: return op_add;
    endcase
  endfunction

  function automatic op_t invalid_op();
    op_t code;
    code = 4'(rand_bits(4));
    if (code inside {op_and, op_or, op_add, op_addu, op_sub, op_slt, op_nor})
      code = 4'hf;
    return code;
  endfunction

  // one in eight invalid
  function automatic op_t random_op();
    logic [2:0] sel;
    sel = 3'(rand_bits(3));
    if (sel == 3'd0)
      return invalid_op();
    return (sel[0]) ? logic_op() : arith_op();
  endfunction

  function automatic alu_req_t make_req(input op_t op, input word_t a, input word_t b);
    alu_req_t r;
    r.tag = next_tag;
    r.op = op;
    r.a = a;
    r.b = b;
    next_tag = next_tag + tag_t'(1);
    return r;
  endfunction

  // reference model of the ALU ops
  function automatic alu_rsp_t predict(input alu_req_t r);
    alu_rsp_t    e;
    logic [32:0] usum;
    longint      sres;
    e = '0;
    e.tag = r.tag;
    case (r.op)
      op_and:  e.result = r.a & r.b;
      op_or:   e.result = r.a | r.b;
      op_nor:  e.result = ~(r.a | r.b);
      op_add,
      op_addu:
      begin
        usum = {1'b0, r.a} + {1'b0, r.b};
        sres = longint'($signed(r.a)) + longint'($signed(r.b));
        e.result = usum[31:0];
        e.cout = usum[32];
        e.overflow = (r.op == op_add) && (sres > word_max || sres < word_min);
      end
      op_sub:
      begin
        sres = longint'($signed(r.a)) - longint'($signed(r.b));
        e.result = r.a - r.b;
        e.cout = (r.a >= r.b);  // carry means no borrow
        e.overflow = (sres > word_max || sres < word_min);
      end
      op_slt:  e.result = ($signed(r.a) < $signed(r.b)) ? 32'd1 : 32'd0;
      default: e.invalid = 1'b1;
    endcase
    e.zero = (e.result == 32'd0);
    return e;
  endfunction

  task automatic check(input logic ok, input string msg);
    check_count++;
    assert (ok)
    else
    begin
      err_count++;
      $display("[FAIL] %0t: %s", $time, msg);
    end
  endtask

  task automatic take_response();
    alu_rsp_t e;
    returned_n++;
    if (expect_q.size() == 0)
    begin
      err_count++;
      $display("response with tag %0h arrived while nothing was outstanding", out_rsp.tag);
    end
    else
    begin
      e = expect_q.pop_front();
      check(out_rsp === e,
            $sformatf("tag %0h got %h z%b c%b v%b i%b, expected tag %0h %h z%b c%b v%b i%b",
                      out_rsp.tag, out_rsp.result, out_rsp.zero, out_rsp.cout,
                      out_rsp.overflow, out_rsp.invalid, e.tag, e.result, e.zero,
                      e.cout, e.overflow, e.invalid));
    end
  endtask

  // drive on the falling edge and sample handshakes once settled
  task automatic step(input logic v, input alu_req_t r, input logic ordy, output logic acc);
    @(negedge clk);
    in_valid = v;
    in_req = r;
    out_ready = ordy;
    #1;
    acc = v && in_ready;
    if (acc)
    begin
      expect_q.push_back(predict(r));
      accepted_n++;
    end
    if (out_valid && ordy)
      take_response();
  endtask

  task automatic send(input alu_req_t r, input logic stress);
    int   n;
    logic acc;
    n = 0;
    acc = 1'b0;
    if (stress && rand_bits(1) == 32'd0)
      step(1'b0, r, |rand_bits(2), acc);  // idle cycle
    while (!acc && n < wait_limit)
    begin
      step(1'b1, r, stress ? |rand_bits(2) : 1'b1, acc);
      n++;
    end
    if (!acc)
    begin
      err_count++;
      $display("timeout: request tag %0h not accepted in %0d cycles", r.tag, wait_limit);
    end
  endtask

  task automatic drain();
    int   n;
    logic acc;
    n = 0;
    while (expect_q.size() != 0 && n < wait_limit)
    begin
      step(1'b0, '0, 1'b1, acc);
      n++;
    end
    if (expect_q.size() != 0)
    begin
      err_count++;
      $display("timeout: %0d responses never came back", expect_q.size());
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, check_count - checks_mark,
             err_count - errs_mark);
    checks_mark = check_count;
    errs_mark = err_count;
  endtask

  initial
  begin
    alu_req_t r;
    int       count;
    logic     acc;
    reset = 1'b1;
    in_valid = 1'b0;
    in_req = '0;
    out_ready = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    check(!out_valid, "out_valid high after reset");
    check(in_ready, "in_ready low after reset");
    finish_test("reset state");

    repeat (40) send(make_req(logic_op(), rand_word(), rand_word()), 1'b0);
    send(make_req(op_slt, 32'hffffffff, 32'd1), 1'b0);  // negative vs positive
    send(make_req(op_slt, 32'd1, 32'hffffffff), 1'b0);
    send(make_req(op_slt, 32'h80000000, 32'h7fffffff), 1'b0);
    send(make_req(op_slt, 32'h12345678, 32'h12345678), 1'b0);
    drain();
    finish_test("logic and slt");

    repeat (60) send(make_req(arith_op(), rand_word(), rand_word()), 1'b0);
    send(make_req(op_add, 32'h7fffffff, 32'd1), 1'b0);
    send(make_req(op_add, 32'h80000000, 32'hffffffff), 1'b0);
    send(make_req(op_sub, 32'h80000000, 32'd1), 1'b0);
    send(make_req(op_sub, 32'h7fffffff, 32'hffffffff), 1'b0);
    send(make_req(op_add, 32'hffffffff, 32'hffffffff), 1'b0);
    send(make_req(op_addu, 32'hffffffff, 32'hffffffff), 1'b0);
    send(make_req(op_sub, 32'd5, 32'd5), 1'b0);
    drain();
    finish_test("add addu sub");

    send(make_req(4'hf, rand_word(), rand_word()), 1'b0);
    repeat (20) send(make_req(invalid_op(), rand_word(), rand_word()), 1'b0);
    drain();
    finish_test("invalid op");

    // fill every lane with the output stalled
    r = make_req(random_op(), rand_word(), rand_word());
    count = 0;
    acc = 1'b1;
    while (acc && count <= num_lanes)
    begin
      step(1'b1, r, 1'b0, acc);
      if (acc)
      begin
        count++;
        r = make_req(random_op(), rand_word(), rand_word());
      end
    end
    check(count == num_lanes, $sformatf("%0d accepts before in_ready fell", count));
    check(out_valid, "out_valid low with all lanes full");
    send(r, 1'b0);
    drain();
    finish_test("back-pressure");

    repeat (300) send(make_req(random_op(), rand_word(), rand_word()), 1'b1);
    drain();
    check(expect_q.size() == 0, "model queue not empty");
    check(returned_n == accepted_n, $sformatf("%0d accepted, %0d returned",
          accepted_n, returned_n));
    finish_test("random stress");

    $display("total: %0d checks, %0d errors, %0d responses", check_count, err_count,
             returned_n);
    if (err_count == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/alu_cluster.sv ====
/* ALU cluster top
   dispatcher, four ALU lanes and an in-order collector */
`default_nettype none
`timescale 1ns/100ps

module alu_cluster
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  alu_req_t in_req,
  output logic     out_valid,
  input  logic     out_ready,
  output alu_rsp_t out_rsp
);

  logic [num_lanes-1:0] lane_valid;
  logic [num_lanes-1:0] lane_ready;
  logic [num_lanes-1:0] lane_rsp_valid;
  logic [num_lanes-1:0] lane_rsp_ready;
  alu_req_t             lane_req;
  alu_rsp_t             lane_rsp [num_lanes];

  op_dispatch u_dispatch (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_req     (in_req),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .lane_req   (lane_req)
  );

  for (genvar i = 0; i < num_lanes; i++)
  begin : g_lane
    alu_lane u_lane (
      .clk       (clk),
      .reset     (reset),
      .req_valid (lane_valid[i]),
      .req_ready (lane_ready[i]),
      .req       (lane_req),
      .rsp_valid (lane_rsp_valid[i]),
      .rsp_ready (lane_rsp_ready[i]),
      .rsp       (lane_rsp[i])
    );
  end

  result_collect u_collect (
    .clk            (clk),
    .reset          (reset),
    .lane_rsp_valid (lane_rsp_valid),
    .lane_rsp       (lane_rsp),
    .lane_rsp_ready (lane_rsp_ready),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_rsp        (out_rsp)
  );

endmodule

`default_nettype wire

// ==== src/result_collect.sv ====
/* result collector
   drains lane responses in issue rotation onto the output port */
`default_nettype none
`timescale 1ns/100ps

module result_collect
  import alu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [num_lanes-1:0] lane_rsp_valid,
  input  alu_rsp_t             lane_rsp [num_lanes],
  output logic [num_lanes-1:0] lane_rsp_ready,
  output logic                 out_valid,
  input  logic                 out_ready,
  output alu_rsp_t             out_rsp
);

  lane_idx_t drain_ptr;

  assign out_valid = lane_rsp_valid[drain_ptr];
  assign out_rsp   = lane_rsp[drain_ptr];

  // only the selected lane sees ready
  always_comb
  begin
    lane_rsp_ready            = '0;
    lane_rsp_ready[drain_ptr] = out_ready;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      drain_ptr <= '0;
    else if (out_valid && out_ready)
      drain_ptr <= next_lane(drain_ptr);
  end

endmodule

`default_nettype wire

// ==== src/op_dispatch.sv ====
/* request dispatcher
   hands requests to the lanes in strict rotation */
`default_nettype none
`timescale 1ns/100ps

module op_dispatch
  import alu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  alu_req_t             in_req,
  output logic [num_lanes-1:0] lane_valid,
  input  logic [num_lanes-1:0] lane_ready,
  output alu_req_t             lane_req
);

  lane_idx_t issue_ptr;

  // shared request bus with only valid steered
  assign lane_req = in_req;

  always_comb
  begin
    lane_valid            = '0;
    lane_valid[issue_ptr] = in_valid;
  end

  // wait on a busy lane rather than skip it to keep order
  assign in_ready = lane_ready[issue_ptr];

  always_ff @(posedge clk)
  begin
    if (reset)
      issue_ptr <= '0;
    else if (in_valid && in_ready)
      issue_ptr <= next_lane(issue_ptr);
  end

endmodule

`default_nettype wire

// ==== alu/alu_lane.sv ====
/* one ALU cluster lane
   single response slot behind alu_32 with valid/ready on both sides */
`default_nettype none
`timescale 1ns/100ps

module alu_lane
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  output logic     req_ready,
  input  alu_req_t req,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output alu_rsp_t rsp
);

  word_t alu_result;
  logic  alu_zero;
  logic  alu_cout;
  logic  alu_ovf;
  logic  alu_inv;
  logic  slot_full;
  logic  accept;

  alu_32 u_alu (
    .input_a             (req.a),
    .input_b             (req.b),
    .control             (req.op),
    .result              (alu_result),
    .zero                (alu_zero),
    .cout                (alu_cout),
    .err_overflow        (alu_ovf),
    .err_invalid_control (alu_inv)
  );

  // free slot, or the held one leaves this cycle
  assign req_ready = !slot_full || rsp_ready;
  assign accept    = req_valid && req_ready;
  assign rsp_valid = slot_full;

  always_ff @(posedge clk)
  begin
    if (reset)
      slot_full <= 1'b0;
    else if (accept)
      slot_full <= 1'b1;
    else if (rsp_ready)
      slot_full <= 1'b0;  // drained
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      rsp <= '{tag: req.tag, result: alu_result, zero: alu_zero,
               cout: alu_cout, overflow: alu_ovf, invalid: alu_inv};
  end

endmodule

`default_nettype wire

// ==== alu/alu_32.sv ====
/* 32-bit MIPS style ALU
   bitwise ops, add/sub with carry and signed overflow, signed compare */
`default_nettype none
`timescale 1ns/100ps

module alu_32
  import alu_pkg::*;
(
  input  word_t input_a,
  input  word_t input_b,
  input  op_t   control,
  output word_t result,
  output logic  zero,
  output logic  cout,
  output logic  err_overflow,
  output logic  err_invalid_control
);

  logic        is_sub;
  word_t       b_eff;
  logic [32:0] sum;
  logic        signed_ovf;
  logic        a_lt_b;

  // subtract is a + ~b + 1
  assign is_sub = (control == op_sub);
  assign b_eff  = is_sub ? ~input_b : input_b;
  assign sum    = {1'b0, input_a} + {1'b0, b_eff} + {32'd0, is_sub};

  // same sign in, different sign out
  assign signed_ovf = (input_a[31] == b_eff[31]) && (sum[31] != input_a[31]);

  assign a_lt_b = $signed(input_a) < $signed(input_b);

  always_comb
  begin
    result              = '0;
    cout                = 1'b0;
    err_overflow        = 1'b0;
    err_invalid_control = 1'b0;
    case (control)
      op_and:  result = input_a & input_b;
      op_or:   result = input_a | input_b;
      op_nor:  result = ~(input_a | input_b);
      op_add,
      op_sub:
      begin
        result       = sum[31:0];
        cout         = sum[32];
        err_overflow = signed_ovf;
      end
      op_addu:
      begin
        result = sum[31:0];
        cout   = sum[32];  // no overflow for unsigned
      end
      op_slt:  result = {31'd0, a_lt_b};
      default: err_invalid_control = 1'b1;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== common/alu_pkg.sv ====
/* alu cluster shared definitions
   word, op code, tag and lane types, op codes and the request/response structs */
`default_nettype none

package alu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  op_t;
  typedef logic [3:0]  tag_t;

  // valid op codes, all others invalid
  localparam op_t op_and  = 4'd0;
  localparam op_t op_or   = 4'd1;
  localparam op_t op_add  = 4'd2;
  localparam op_t op_addu = 4'd3;
  localparam op_t op_sub  = 4'd6;
  localparam op_t op_slt  = 4'd7;
  localparam op_t op_nor  = 4'd12;

  localparam int num_lanes = 4;

  typedef logic [$clog2(num_lanes)-1:0] lane_idx_t;

  typedef struct packed {
    tag_t  tag;
    op_t   op;
    word_t a;
    word_t b;
  } alu_req_t;

  typedef struct packed {
    tag_t  tag;
    word_t result;
    logic  zero;
    logic  cout;
    logic  overflow;
    logic  invalid;
  } alu_rsp_t;

  // rotation step shared by issue and drain pointers
  function automatic lane_idx_t next_lane(input lane_idx_t idx);
    lane_idx_t nxt;
    if (idx == lane_idx_t'(num_lanes - 1))
      nxt = '0;
    else
      nxt = idx + lane_idx_t'(1);
    return nxt;
  endfunction

endpackage

`default_nettype wire
